/* gem_rx_top.f */
design/gem_rx_pkg.sv
design/gem_link_monitor.sv
design/gem_bx_delay.sv
design/gem_rx_regs.sv
design/gem_rx_top.sv
verif/gem_rx_chk.sv
verif/gem_rx_scoreboard.sv
verif/tb_gem_rx.sv

/* verif/tb_gem_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_gem_rx;
  import gem_rx_pkg::*;

  localparam int timeout_cycles = 200;  // Per handshake or status wait

  logic                       clock;
  logic                       gtx_rx_reset;
  logic                       ttc_resync;
  gem_frame_t [num_links-1:0] rx_data;
  logic       [num_links-1:0] rx_valid;
  logic       [num_links-1:0] rx_match;
  kchar_t     [num_links-1:0] rx_kchar;
  logic       [num_links-1:0] rx_code_err;
  gem_frame_t [num_links-1:0] gem_data_out;
  logic       [num_links-1:0] link_good;
  axi_addr_t                  awaddr;
  logic                       awvalid;
  logic                       awready;
  axi_data_t                  wdata;
  logic                       wvalid;
  logic                       wready;
  logic [1:0]                 bresp;
  logic                       bvalid;
  logic                       bready;
  axi_addr_t                  araddr;
  logic                       arvalid;
  logic                       arready;
  axi_data_t                  rdata;
  logic [1:0]                 rresp;
  logic                       rvalid;
  logic                       rready;
  int                         miss_pct;   // Error rates for the current phase
  int                         cerr_pct;
  int                         kchar_pct;
  int                         tb_errors;
  int                         sb_errors;
  int                         chk_errors;

  // Port names match the testbench signals
  gem_rx_top u_gem_rx_top (.*);
  gem_rx_scoreboard u_scoreboard (.errors(sb_errors), .*);
  bind gem_rx_regs gem_rx_chk u_chk (.*);

  initial clock = 1'b0;
  always #50 clock = ~clock;            // 100 ns period

  //------------------------------------------------------------
  // Random frames on every falling edge
  //------------------------------------------------------------
  task automatic drive_frames();
    for (int l = 0; l < num_links; l++) begin
      rx_data[l]     = gem_frame_t'({$urandom, $urandom});
      rx_valid[l]    = ($urandom % 100) < 90;
      rx_match[l]    = ($urandom % 100) >= miss_pct;
      rx_code_err[l] = ($urandom % 100) < cerr_pct;
      rx_kchar[l]    = (($urandom % 100) < kchar_pct) ? kchar_t'(1 << ($urandom % 8)) : '0;
    end
  endtask

  task automatic report_timeout(string channel);
    $display("Timeout: the %s channel got no handshake within %0d cycles at %0t ns",
             channel, timeout_cycles, $time);
    tb_errors++;
  endtask

  task automatic run_frames(int n);
    repeat (n) @(negedge clock);
  endtask

  //------------------------------------------------------------
  // AXI4-Lite master
  //------------------------------------------------------------
  task automatic bus_write(axi_addr_t addr, axi_data_t data);
    int n;
    @(negedge clock);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    for (n = 0; n < timeout_cycles; n++) begin
      @(posedge clock);
      if (awready && wready) break;
    end
    if (n == timeout_cycles) report_timeout("write address and data");
    @(negedge clock);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat ($urandom % 4) @(negedge clock);   // Random bready stall
    bready = 1'b1;
    for (n = 0; n < timeout_cycles; n++) begin
      @(posedge clock);
      if (bvalid) break;
    end
    if (n == timeout_cycles) report_timeout("write response");
    @(negedge clock);
    bready = 1'b0;
  endtask

  task automatic bus_read(axi_addr_t addr);
    int n;
    @(negedge clock);
    araddr  = addr;
    arvalid = 1'b1;
    for (n = 0; n < timeout_cycles; n++) begin
      @(posedge clock);
      if (arready) break;
    end
    if (n == timeout_cycles) report_timeout("read address");
    @(negedge clock);
    arvalid = 1'b0;
    repeat ($urandom % 4) @(negedge clock);   // Random rready stall
    rready = 1'b1;
    for (n = 0; n < timeout_cycles; n++) begin
      @(posedge clock);
      if (rvalid) break;
    end
    if (n == timeout_cycles) report_timeout("read data");
    @(negedge clock);
    rready = 1'b0;
  endtask

  // Status then error count of every link
  task automatic read_link_regs();
    for (int l = 0; l < num_links; l++) begin
      bus_read(axi_addr_t'(reg_link_base + 8 * l));
      bus_read(axi_addr_t'(reg_link_base + 8 * l + 4));
    end
  endtask

  task automatic wait_links_good();
    int n;
    for (n = 0; n < timeout_cycles; n++) begin
      @(posedge clock);
      if (&link_good) break;
    end
    if (n == timeout_cycles) begin
      $display("Timeout: links never reported good after a clean run at %0t ns", $time);
      tb_errors++;
    end
  endtask

  //------------------------------------------------------------
  // Test sequence
  //------------------------------------------------------------
  initial begin
    void'($urandom(32'h4f7f_27e5));
    gtx_rx_reset = 1'b1;
    ttc_resync   = 1'b0;
    rx_data      = '0;
    rx_valid     = '0;
    rx_match     = '0;
    rx_kchar     = '0;
    rx_code_err  = '0;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    miss_pct     = 0;
    cerr_pct     = 0;
    kchar_pct    = 0;
    tb_errors    = 0;
    // Frame driver inherits the seeded generator
    fork
      forever begin
        @(negedge clock);
        drive_frames();
      end
    join_none
    repeat (5) @(posedge clock);
    @(negedge clock);
    gtx_rx_reset = 1'b0;
    wait_links_good();                  // Clean traffic qualifies both fibers

    // Random delay codes and PRBS enables
    for (int i = 0; i < 8; i++) begin
      bus_write(reg_ctrl, $urandom & 32'h0000_ff03);
      run_frames(40);
      bus_read(reg_ctrl);
    end

    // PRBS mismatches, count follows prbs_en
    miss_pct = 20;
    bus_write(reg_ctrl, 32'h0000_5303);
    run_frames(100);
    read_link_regs();
    bus_write(reg_ctrl, 32'h0000_5300);
    read_link_regs();
    miss_pct = 0;

    // Code errors and stray K-chars drop link_good
    cerr_pct  = 4;
    kchar_pct = 4;
    run_frames(60);
    read_link_regs();
    cerr_pct  = 0;
    kchar_pct = 0;
    wait_links_good();

    // Burst to saturation, then resync
    cerr_pct = 100;
    run_frames(320);
    read_link_regs();
    cerr_pct = 0;
    @(negedge clock);
    ttc_resync = 1'b1;
    @(negedge clock);
    ttc_resync = 1'b0;
    read_link_regs();

    // Unmapped and read-only targets, random reads
    bus_write(8'h24, 32'hdead_beef);
    bus_write(reg_link_base, 32'h0000_0001);
    bus_read(8'h08);
    for (int i = 0; i < 24; i++) begin
      bus_read(axi_addr_t'($urandom % 64));
    end
    for (int i = 0; i < 6; i++) begin
      bus_write(reg_ctrl, $urandom & 32'h0000_ff03);
      bus_read(reg_ctrl);
    end

    run_frames(20);
    chk_errors = u_gem_rx_top.u_regs.u_chk.fail_count;
    $display("Errors: scoreboard %0d, testbench %0d, assertions %0d",
             sb_errors, tb_errors, chk_errors);
    if (sb_errors + tb_errors + chk_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/gem_rx_scoreboard.sv */
`timescale 1ns/100ps
`default_nettype none

module gem_rx_scoreboard (
  input  wire                                                  clock,
  input  wire                                                  gtx_rx_reset,
  input  wire                                                  ttc_resync,
  input  wire gem_rx_pkg::gem_frame_t [gem_rx_pkg::num_links-1:0] rx_data,
  input  wire [gem_rx_pkg::num_links-1:0]                      rx_valid,
  input  wire [gem_rx_pkg::num_links-1:0]                      rx_match,
  input  wire gem_rx_pkg::kchar_t [gem_rx_pkg::num_links-1:0]  rx_kchar,
  input  wire [gem_rx_pkg::num_links-1:0]                      rx_code_err,
  input  wire gem_rx_pkg::gem_frame_t [gem_rx_pkg::num_links-1:0] gem_data_out,
  input  wire [gem_rx_pkg::num_links-1:0]                      link_good,
  input  wire gem_rx_pkg::axi_addr_t                           awaddr,
  input  wire                                                  awvalid,
  input  wire                                                  awready,
  input  wire gem_rx_pkg::axi_data_t                           wdata,
  input  wire [1:0]                                            bresp,
  input  wire                                                  bvalid,
  input  wire                                                  bready,
  input  wire gem_rx_pkg::axi_addr_t                           araddr,
  input  wire                                                  arvalid,
  input  wire                                                  arready,
  input  wire gem_rx_pkg::axi_data_t                           rdata,
  input  wire [1:0]                                            rresp,
  input  wire                                                  rvalid,
  input  wire                                                  rready,
  output int                                                   errors
);
  import gem_rx_pkg::*;

  // Per-link model state
  int         link_cnt [num_links];     // Saturates at 255
  int         prbs_cnt [num_links];     // Saturates at 65535
  int         run_len  [num_links];     // Clean valid frames, parks at good_run_len
  bit         good     [num_links];
  bit         bad      [num_links];
  bit         had_err  [num_links];
  bit         perr     [num_links];
  gem_frame_t hist     [num_links][16]; // hist[l][k] entered k edges back
  gem_frame_t exp_dout [num_links];
  axi_data_t  ctrl;                     // Model control register
  axi_data_t  rdata_q [$];              // Expected read words in order
  logic [1:0] rresp_q [$];
  logic [1:0] bresp_q [$];

  initial errors = 0;

  task automatic report_mismatch(string what, logic [63:0] got, logic [63:0] exp);
    $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
    errors++;
  endtask

  // Control word plus two status/count windows
  function automatic bit is_mapped(axi_addr_t a);
    if (a == reg_ctrl) return 1'b1;
    return (a >= reg_link_base) && (a < reg_link_base + 8 * num_links) && (a[1:0] == 2'b00);
  endfunction

  function automatic axi_data_t model_read(axi_addr_t a);
    int l;
    if (a == reg_ctrl) return ctrl;
    if (!is_mapped(a)) return '0;      // Unmapped reads give zero
    l = (a - reg_link_base) >> 3;
    if (a[2]) return axi_data_t'(ctrl[l] ? prbs_cnt[l] : link_cnt[l]);
    return {28'b0, perr[l], had_err[l], bad[l], good[l]};
  endfunction

  //------------------------------------------------------------
  // Link model, one step per clock edge
  //------------------------------------------------------------
  task automatic step_links();
    bit ferr;
    bit miss;
    for (int l = 0; l < num_links; l++) begin
      ferr = rx_valid[l] && (rx_code_err[l] || (rx_kchar[l] != '0));
      miss = ctrl[l] && rx_valid[l] && !rx_match[l];
      for (int k = 15; k > 0; k--) hist[l][k] = hist[l][k-1];
      hist[l][0]  = (good[l] && !bad[l]) ? rx_data[l] : '0;  // Health before this edge
      exp_dout[l] = hist[l][ctrl[8 + 4 * l +: 4]];           // Tap code+1 back
      if (ttc_resync) begin
        link_cnt[l] = 0;
        prbs_cnt[l] = 0;
        run_len[l]  = 0;
        had_err[l]  = 0;
        perr[l]     = 0;
      end else begin
        if (ferr && link_cnt[l] < 255) link_cnt[l]++;
        if (miss && prbs_cnt[l] < 65535) prbs_cnt[l]++;
        if (ferr) had_err[l] = 1;
        perr[l] = miss;
        if (ferr) run_len[l] = 0;
        else if (rx_valid[l] && run_len[l] < good_run_len) run_len[l]++;
      end
      bad[l]  = (link_cnt[l] == 255);
      good[l] = (run_len[l] >= good_run_len);
    end
  endtask

  //------------------------------------------------------------
  // Compare, then advance the model
  //------------------------------------------------------------
  always @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      for (int l = 0; l < num_links; l++) begin
        link_cnt[l] = 0;
        prbs_cnt[l] = 0;
        run_len[l]  = 0;
        {good[l], bad[l], had_err[l], perr[l]} = '0;
        exp_dout[l] = '0;
        for (int k = 0; k < 16; k++) hist[l][k] = '0;
      end
      ctrl = '0;
      rdata_q.delete();
      rresp_q.delete();
      bresp_q.delete();
    end else begin
      for (int l = 0; l < num_links; l++) begin
        if (gem_data_out[l] !== exp_dout[l])
          report_mismatch($sformatf("gem_data_out[%0d]", l), gem_data_out[l], exp_dout[l]);
        if (link_good[l] !== good[l])
          report_mismatch($sformatf("link_good[%0d]", l), link_good[l], good[l]);
      end
      if (bvalid && bready) begin
        if (bresp_q.size() == 0) begin
          $display("Write response arrived with no write outstanding at %0t ns", $time);
          errors++;
        end else if (bresp !== bresp_q[0]) begin
          report_mismatch("bresp", bresp, bresp_q[0]);
        end
        if (bresp_q.size() != 0) void'(bresp_q.pop_front());
      end
      if (rvalid && rready) begin
        if (rdata_q.size() == 0) begin
          $display("Read response arrived with no read outstanding at %0t ns", $time);
          errors++;
        end else begin
          if (rdata !== rdata_q[0]) report_mismatch("rdata", rdata, rdata_q[0]);
          if (rresp !== rresp_q[0]) report_mismatch("rresp", rresp, rresp_q[0]);
          void'(rdata_q.pop_front());
          void'(rresp_q.pop_front());
        end
      end
      if (arvalid && arready) begin     // Snapshot before the counters move
        rdata_q.push_back(model_read(araddr));
        rresp_q.push_back(is_mapped(araddr) ? 2'b00 : 2'b10);
      end
      step_links();
      if (awvalid && awready) begin     // New control is live from the next edge
        bresp_q.push_back(is_mapped(awaddr) ? 2'b00 : 2'b10);
        if (awaddr == reg_ctrl) ctrl = wdata & 32'h0000_ff03;
      end
    end
  end

endmodule

`default_nettype wire

/* verif/gem_rx_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module gem_rx_chk (
  input  wire                         clock,
  input  wire                         gtx_rx_reset,
  input  wire gem_rx_pkg::axi_state_t state,     // Bus FSM inside the register block
  input  wire                         awready,
  input  wire                         wready,
  input  wire                         arready,
  input  wire                         bvalid,
  input  wire                         bready,
  input  wire                         rvalid,
  input  wire                         rready,
  input  wire gem_rx_pkg::axi_data_t  rdata,
  input  wire [1:0]                   rresp
);
  import gem_rx_pkg::*;

  int fail_count = 0;                   // Read by the testbench at the end

  //------------------------------------------------------------
  // Response channels hold until taken
  //------------------------------------------------------------
  a_bvalid_hold: assert property (@(posedge clock) disable iff (gtx_rx_reset)
    bvalid && !bready |=> bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  a_rvalid_hold: assert property (@(posedge clock) disable iff (gtx_rx_reset)
    rvalid && !rready |=> rvalid)
    else begin
      $error("rvalid dropped before rready");
      fail_count++;
    end

  // Read word frozen while the master stalls
  a_rdata_stable: assert property (@(posedge clock) disable iff (gtx_rx_reset)
    rvalid && !rready |=> $stable(rdata) && $stable(rresp))
    else begin
      $error("rdata or rresp changed while rvalid waited");
      fail_count++;
    end

  //------------------------------------------------------------
  // An accepted request moves the FSM out of idle
  //------------------------------------------------------------
  a_ready_idle: assert property (@(posedge clock) disable iff (gtx_rx_reset)
    (awready || wready || arready) |=> (state != idle))
    else begin
      $error("bus FSM stayed in idle after a handshake");
      fail_count++;
    end

endmodule

`default_nettype wire

/* design/gem_rx_top.sv */
`timescale 1ns/100ps
`default_nettype none

module gem_rx_top (
  input  wire                                                clock,
  input  wire                                                gtx_rx_reset,
  input  wire                                                ttc_resync,
  // Decoded fiber inputs, one entry per link
  input  wire gem_rx_pkg::gem_frame_t [gem_rx_pkg::num_links-1:0] rx_data,
  input  wire [gem_rx_pkg::num_links-1:0]                    rx_valid,
  input  wire [gem_rx_pkg::num_links-1:0]                    rx_match,
  input  wire gem_rx_pkg::kchar_t [gem_rx_pkg::num_links-1:0] rx_kchar,
  input  wire [gem_rx_pkg::num_links-1:0]                    rx_code_err,
  // Delayed cluster data and health
  output gem_rx_pkg::gem_frame_t [gem_rx_pkg::num_links-1:0] gem_data_out,
  output logic [gem_rx_pkg::num_links-1:0]                   link_good,
  // AXI4-Lite slave
  input  wire gem_rx_pkg::axi_addr_t                         awaddr,
  input  wire                                                awvalid,
  output logic                                               awready,
  input  wire gem_rx_pkg::axi_data_t                         wdata,
  input  wire                                                wvalid,
  output logic                                               wready,
  output logic [1:0]                                         bresp,
  output logic                                               bvalid,
  input  wire                                                bready,
  input  wire gem_rx_pkg::axi_addr_t                         araddr,
  input  wire                                                arvalid,
  output logic                                               arready,
  output gem_rx_pkg::axi_data_t                              rdata,
  output logic [1:0]                                         rresp,
  output logic                                               rvalid,
  input  wire                                                rready
);
  import gem_rx_pkg::*;

  logic       [num_links-1:0] prbs_en;      // From control register
  bx_delay_t  [num_links-1:0] bx_delay;
  logic       [num_links-1:0] link_bad;     // Monitor status
  logic       [num_links-1:0] link_had_err;
  logic       [num_links-1:0] prbs_err;
  err_count_t [num_links-1:0] err_count;
  logic       [num_links-1:0] ignore_link;  // Monitor to delay line

  //----------------------------------------------------------
  // Per-fiber monitor and delay line
  //----------------------------------------------------------
  for (genvar i = 0; i < num_links; i++) begin : g_link
    gem_link_monitor u_monitor (
      .clock        (clock),
      .gtx_rx_reset (gtx_rx_reset),
      .ttc_resync   (ttc_resync),
      .prbs_en      (prbs_en[i]),
      .rx_valid     (rx_valid[i]),
      .rx_match     (rx_match[i]),
      .rx_code_err  (rx_code_err[i]),
      .rx_kchar     (rx_kchar[i]),
      .link_good    (link_good[i]),
      .link_bad     (link_bad[i]),
      .link_had_err (link_had_err[i]),
      .prbs_err     (prbs_err[i]),
      .err_count    (err_count[i]),
      .ignore_link  (ignore_link[i])
    );

    gem_bx_delay u_delay (
      .clock        (clock),
      .gtx_rx_reset (gtx_rx_reset),
      .bx_delay     (bx_delay[i]),
      .ignore_link  (ignore_link[i]),
      .din          (rx_data[i]),
      .dout         (gem_data_out[i])
    );
  end

  // Shared register block, reads counters directly
  gem_rx_regs u_regs (
    .clock        (clock),
    .gtx_rx_reset (gtx_rx_reset),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .prbs_en      (prbs_en),
    .bx_delay     (bx_delay),
    .link_good    (link_good),
    .link_bad     (link_bad),
    .link_had_err (link_had_err),
    .prbs_err     (prbs_err),
    .err_count    (err_count)
  );

endmodule

`default_nettype wire

/* design/gem_rx_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module gem_rx_regs (
  input  wire                         clock,
  input  wire                         gtx_rx_reset,
  // AXI4-Lite write address and data
  input  wire gem_rx_pkg::axi_addr_t  awaddr,
  input  wire                         awvalid,
  output logic                        awready,
  input  wire gem_rx_pkg::axi_data_t  wdata,
  input  wire                         wvalid,
  output logic                        wready,
  // Write response
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  wire                         bready,
  // Read address and data
  input  wire gem_rx_pkg::axi_addr_t  araddr,
  input  wire                         arvalid,
  output logic                        arready,
  output gem_rx_pkg::axi_data_t       rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  wire                         rready,
  // Control to the links
  output logic [gem_rx_pkg::num_links-1:0]                 prbs_en,
  output gem_rx_pkg::bx_delay_t [gem_rx_pkg::num_links-1:0] bx_delay,
  // Status from the monitors
  input  wire [gem_rx_pkg::num_links-1:0]                   link_good,
  input  wire [gem_rx_pkg::num_links-1:0]                   link_bad,
  input  wire [gem_rx_pkg::num_links-1:0]                   link_had_err,
  input  wire [gem_rx_pkg::num_links-1:0]                   prbs_err,
  input  wire gem_rx_pkg::err_count_t [gem_rx_pkg::num_links-1:0] err_count
);
  import gem_rx_pkg::*;

  axi_state_t state;
  axi_data_t  ctrl_q;                   // Control register, undefined bits kept zero
  axi_data_t  rd_word;                  // Read mux output
  logic       wr_go;                    // Write handshake this cycle
  logic       rd_go;                    // Read handshake this cycle

  // Address of a register inside a link window
  function automatic axi_addr_t link_addr(int link, axi_addr_t ofs);
    return axi_addr_t'(reg_link_base + link * reg_link_stride + ofs);
  endfunction

  // Any decoded register, status and count are read only
  function automatic logic addr_mapped(axi_addr_t addr);
    logic hit;
    hit = (addr == reg_ctrl);
    for (int i = 0; i < num_links; i++) begin
      hit = hit | (addr == link_addr(i, reg_status_ofs))
                | (addr == link_addr(i, reg_errcnt_ofs));
    end
    return hit;
  endfunction

  //----------------------------------------------------------
  // Handshakes
  //----------------------------------------------------------
  assign wr_go   = (state == idle) & awvalid & wvalid;   // Needs address and data together
  assign rd_go   = (state == idle) & arvalid & ~wr_go;   // Write wins a tie
  assign awready = wr_go;
  assign wready  = wr_go;
  assign arready = rd_go;
  assign bvalid  = (state == write_resp);
  assign rvalid  = (state == read_resp);

  //----------------------------------------------------------
  // Read mux
  //----------------------------------------------------------
  always_comb begin
    rd_word = '0;                       // Unmapped reads return zero
    if (araddr == reg_ctrl) begin
      rd_word = ctrl_q;
    end
    for (int i = 0; i < num_links; i++) begin
      if (araddr == link_addr(i, reg_status_ofs)) begin
        // Bits 3..0 are prbs_err, had_err, bad, good
        rd_word = axi_data_t'({prbs_err[i], link_had_err[i], link_bad[i], link_good[i]});
      end
      if (araddr == link_addr(i, reg_errcnt_ofs)) begin
        rd_word = axi_data_t'(err_count[i]);
      end
    end
  end

  //----------------------------------------------------------
  // Bus FSM and control register
  //----------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      state  <= idle;
      ctrl_q <= '0;                     // PRBS off, zero delay
      bresp  <= resp_okay;
      rresp  <= resp_okay;
      rdata  <= '0;
    end else begin
      case (state)
        idle: begin
          if (wr_go) begin
            state <= write_resp;
            bresp <= addr_mapped(awaddr) ? resp_okay : resp_slverr;
            if (awaddr == reg_ctrl) begin
              ctrl_q <= wdata & ctrl_mask;   // Live on the next cycle
            end
          end else if (rd_go) begin
            state <= read_resp;
            rdata <= rd_word;           // Snapshot at the ar handshake
            rresp <= addr_mapped(araddr) ? resp_okay : resp_slverr;
          end
        end
        write_resp: begin
          if (bready) begin
            state <= idle;              // Hold bvalid until taken
          end
        end
        read_resp: begin
          if (rready) begin
            state <= idle;              // rdata frozen while waiting
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Control fields out to each link
  always_comb begin
    prbs_en = ctrl_q[num_links-1:0];
    for (int i = 0; i < num_links; i++) begin
      bx_delay[i] = ctrl_q[ctrl_delay_lsb + i * $bits(bx_delay_t) +: $bits(bx_delay_t)];
    end
  end

endmodule

`default_nettype wire

/* design/gem_bx_delay.sv */
`timescale 1ns/100ps
`default_nettype none

module gem_bx_delay (
  input  wire                        clock,
  input  wire                        gtx_rx_reset,
  input  wire gem_rx_pkg::bx_delay_t bx_delay,     // Tap select, latency is code+1
  input  wire                        ignore_link,  // Blank frames from an unhealthy fiber
  input  wire gem_rx_pkg::gem_frame_t din,
  output gem_rx_pkg::gem_frame_t     dout
);
  import gem_rx_pkg::*;

  gem_frame_t entry;                    // Frame after the bad-link gate
  gem_frame_t pipe_q [bx_depth-1];      // 15 stages, output register is the 16th
  gem_frame_t taps   [bx_depth];        // Tap k holds the frame from k cycles back

  //----------------------------------------------------------
  // Entry gate and tap list
  //----------------------------------------------------------
  always_comb begin
    entry   = ignore_link ? '0 : din;   // Gate uses health at capture time
    taps[0] = entry;                    // Code 0, straight into the output register
    for (int k = 1; k < bx_depth; k++) begin
      taps[k] = pipe_q[k-1];
    end
  end

  //----------------------------------------------------------
  // Shift register and registered tap
  //----------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      for (int k = 0; k < bx_depth - 1; k++) begin
        pipe_q[k] <= '0;
      end
      dout <= '0;
    end else begin
      pipe_q[0] <= entry;
      for (int k = 1; k < bx_depth - 1; k++) begin
        pipe_q[k] <= pipe_q[k-1];       // Runs every cycle, valid or not
      end
      dout <= taps[bx_delay];
    end
  end

endmodule

`default_nettype wire

/* design/gem_link_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module gem_link_monitor (
  input  wire                        clock,
  input  wire                        gtx_rx_reset,
  input  wire                        ttc_resync,    // Clears counts, sticky bits and good run
  input  wire                        prbs_en,       // PRBS test mode for this fiber
  input  wire                        rx_valid,      // Decoder has a frame this cycle
  input  wire                        rx_match,      // PRBS pattern matched
  input  wire                        rx_code_err,   // 8b/10b code violation
  input  wire gem_rx_pkg::kchar_t    rx_kchar,      // Any K-char inside a data frame is an error
  output logic                       link_good,
  output logic                       link_bad,
  output logic                       link_had_err,
  output logic                       prbs_err,      // Mismatch on the last frame
  output gem_rx_pkg::err_count_t     err_count,
  output logic                       ignore_link    // Zero this fiber's data downstream
);
  import gem_rx_pkg::*;

  link_err_t             link_cnt;       // Saturating link error count
  link_err_t             link_cnt_nxt;
  err_count_t            prbs_cnt;       // Saturating PRBS error count
  err_count_t            prbs_cnt_nxt;
  logic [good_run_w-1:0] clean_run;      // Consecutive clean valid frames
  logic                  frame_err;
  logic                  frame_clean;
  logic                  prbs_miss;
  logic                  run_done;

  //----------------------------------------------------------
  // Frame classification
  //----------------------------------------------------------
  always_comb begin
    frame_err   = rx_valid & (rx_code_err | (|rx_kchar));  // Bad symbol or stray K-char
    frame_clean = rx_valid & ~frame_err;
    prbs_miss   = prbs_en & rx_valid & ~rx_match;          // Valid means a match was due
    // Last clean frame of the qualifying run
    run_done    = frame_clean & (clean_run == good_run_w'(good_run_len - 1));
  end

  // Both counters stick at all ones
  always_comb begin
    link_cnt_nxt = link_cnt;
    prbs_cnt_nxt = prbs_cnt;
    if (frame_err && (link_cnt != '1)) begin
      link_cnt_nxt = link_cnt + 1'b1;
    end
    if (prbs_miss && (prbs_cnt != '1)) begin
      prbs_cnt_nxt = prbs_cnt + 1'b1;
    end
  end

  //----------------------------------------------------------
  // Error counters and sticky flags
  //----------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      link_cnt     <= '0;
      prbs_cnt     <= '0;
      link_bad     <= 1'b0;
      link_had_err <= 1'b0;
      prbs_err     <= 1'b0;
    end else if (ttc_resync) begin      // Resync wins over any error this cycle
      link_cnt     <= '0;
      prbs_cnt     <= '0;
      link_bad     <= 1'b0;
      link_had_err <= 1'b0;
      prbs_err     <= 1'b0;
    end else begin
      link_cnt <= link_cnt_nxt;
      prbs_cnt <= prbs_cnt_nxt;
      link_bad <= &link_cnt_nxt;        // Saturated link count
      prbs_err <= prbs_miss;            // Single cycle per bad frame
      if (frame_err) begin
        link_had_err <= 1'b1;
      end
    end
  end

  //----------------------------------------------------------
  // Good-link qualification
  //----------------------------------------------------------
  // Invalid frames neither break nor extend the run
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      clean_run <= '0;
      link_good <= 1'b0;
    end else if (ttc_resync) begin
      clean_run <= '0;
      link_good <= 1'b0;
    end else if (frame_err) begin
      clean_run <= '0;                  // Start qualifying over
      link_good <= 1'b0;
    end else if (run_done) begin
      link_good <= 1'b1;                // Run length reached, counter parks here
    end else if (frame_clean) begin
      clean_run <= clean_run + 1'b1;
    end
  end

  // Readout count follows the test mode
  assign err_count   = prbs_en ? prbs_cnt : err_count_t'(link_cnt);
  assign ignore_link = ~link_good | link_bad;

endmodule

`default_nettype wire

/* design/gem_rx_pkg.sv */
`default_nettype none

package gem_rx_pkg;

  //----------------------------------------------------------
  // Link geometry and payload widths
  //----------------------------------------------------------
  localparam int num_links    = 2;              // Fibers handled by this back end
  localparam int good_run_len = 64;             // Clean frames before a link counts as good
  localparam int good_run_w   = $clog2(good_run_len);
  localparam int bx_depth     = 16;             // Delay taps, codes 0..15

  typedef logic [55:0] gem_frame_t;             // One bunch-crossing cluster frame
  typedef logic [7:0]  kchar_t;                 // K-character flag per byte
  typedef logic [15:0] err_count_t;             // PRBS error count
  typedef logic [7:0]  link_err_t;              // Saturating link error count
  typedef logic [3:0]  bx_delay_t;              // Code n gives n+1 cycles

  //----------------------------------------------------------
  // Register bus
  //----------------------------------------------------------
  typedef logic [7:0]  axi_addr_t;
  typedef logic [31:0] axi_data_t;

  typedef enum logic [1:0] {idle, write_resp, read_resp} axi_state_t;

  localparam axi_addr_t reg_ctrl        = 8'h00;
  localparam axi_addr_t reg_link_base   = 8'h10;  // First link window
  localparam axi_addr_t reg_link_stride = 8'h08;  // Window size per link
  localparam axi_addr_t reg_status_ofs  = 8'h00;
  localparam axi_addr_t reg_errcnt_ofs  = 8'h04;
  localparam axi_data_t ctrl_mask       = 32'h0000_ff03;  // PRBS enables and delay codes
  localparam int        ctrl_delay_lsb  = 8;              // Link 0 delay code position
  localparam logic [1:0] resp_okay      = 2'b00;
  localparam logic [1:0] resp_slverr    = 2'b10;

endpackage

`default_nettype wire
